// File: logic/fetch_pkg.sv
// instruction fetch front end, shared definitions
// widths, byte address type and the items passed between fetch stages
package fetch_pkg;

    // address and instruction width
    parameter int XLEN = 32;

    typedef logic [XLEN-1:0] addr_t;

    // fetched word, assembled byte by byte, consumed as one instruction
    typedef union packed {
        logic [3:0][7:0] bytes;
        logic [XLEN-1:0] word;
    } insn_word_u;

    // one item in the cache read stage
    typedef struct packed {
        logic  valid;
        addr_t pc;
    } lookup_t;

    // one item toward decode
    typedef struct packed {
        logic       valid;
        addr_t      pc;
        insn_word_u insn;
    } fetch_t;

    // pc redirect or resume request
    typedef struct packed {
        logic  valid;
        addr_t pc;
    } redirect_t;

    // cache line write
    typedef struct packed {
        logic       valid;
        addr_t      pc;
        insn_word_u data;
    } fill_t;

endpackage

// File: logic/fetch_pc.sv
// fetch pc stage
// holds the pc and the decode credit counter, launches one cache
// lookup per cycle while credits last and the miss engine is idle
`timescale 1ns/1ns

module fetch_pc import fetch_pkg::*; #(
    parameter int CREDITS = 2
) (
    input  logic      clk,
    input  logic      rst_n_i,
    input  redirect_t redirect_i,
    input  redirect_t resume_i,
    input  logic [1:0] drop_cnt_i,
    input  logic      credit_return_i,
    input  logic      fill_busy_i,
    output lookup_t   lookup_o
);

    localparam int CNT_W = $clog2(CREDITS + 1);

    addr_t            pc_q;
    logic [CNT_W-1:0] credits_q;
    // two spare bits so a refund overflow shows up in the check below
    logic [CNT_W+1:0] credits_sum;
    lookup_t          lookup_q;
    logic             launch;

    // redirect or resume loads the pc first, launch follows next cycle
    assign launch = (credits_q != '0) && !fill_busy_i
                    && !redirect_i.valid && !resume_i.valid;

    // spend one per launch, refund returns and drops
    assign credits_sum = {2'b00, credits_q}
                         + (CNT_W + 2)'(credit_return_i)
                         + (CNT_W + 2)'(drop_cnt_i)
                         - (CNT_W + 2)'(launch);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pc_q           <= '0;
            credits_q      <= CNT_W'(CREDITS);
            lookup_q.valid <= 1'b0;
        end else begin
            credits_q      <= credits_sum[CNT_W-1:0];
            lookup_q.valid <= launch;
            // redirect wins over a resume
            if (redirect_i.valid) begin
                pc_q <= redirect_i.pc;
            end else if (resume_i.valid) begin
                pc_q <= resume_i.pc;
            end else if (launch) begin
                pc_q <= pc_q + XLEN'(4);
            end
        end
    end

    // launched address, payload only
    always_ff @(posedge clk) begin
        if (launch) begin
            lookup_q.pc <= pc_q;
        end
    end

    assign lookup_o = lookup_q;

    // refunds never push the counter past the decode buffer depth
    a_credit_max: assert property (@(posedge clk) disable iff (!rst_n_i)
        credits_sum <= (CNT_W + 2)'(CREDITS));

    // launched pcs stay on word boundaries
    a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n_i)
        lookup_o.valid |-> (lookup_o.pc[1:0] == 2'b00));

endmodule

// File: logic/icache.sv
// direct mapped instruction cache
// one word per line, registered read, write port driven by the miss engine
`timescale 1ns/1ns

module icache import fetch_pkg::*; #(
    parameter int INDEX_W = 4
) (
    input  logic       clk,
    input  logic       rst_n_i,
    input  lookup_t    lookup_i,
    input  fill_t      fill_i,
    output lookup_t    lookup_o,
    output logic       hit_o,
    output insn_word_u data_o
);

    localparam int LINES = 1 << INDEX_W;
    localparam int TAG_W = XLEN - INDEX_W - 2;

    // line storage
    logic [LINES-1:0] valid_q;
    logic [TAG_W-1:0] tag_q [LINES];
    insn_word_u       data_q [LINES];

    logic [INDEX_W-1:0] rd_idx;
    logic [INDEX_W-1:0] wr_idx;
    logic [TAG_W-1:0]   rd_tag;

    lookup_t    item_q;
    logic       hit_q;
    insn_word_u word_q;

    // word offset bits select the line, the rest is tag
    assign rd_idx = lookup_i.pc[INDEX_W+1:2];
    assign rd_tag = lookup_i.pc[XLEN-1:INDEX_W+2];
    assign wr_idx = fill_i.pc[INDEX_W+1:2];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_q      <= '0;
            item_q.valid <= 1'b0;
            hit_q        <= 1'b0;
        end else begin
            item_q.valid <= lookup_i.valid;
            hit_q        <= lookup_i.valid && valid_q[rd_idx]
                            && (tag_q[rd_idx] == rd_tag);
            if (fill_i.valid) begin
                valid_q[wr_idx] <= 1'b1;
            end
        end
    end

    // tag and data write
    always_ff @(posedge clk) begin
        if (fill_i.valid) begin
            tag_q[wr_idx]  <= fill_i.pc[XLEN-1:INDEX_W+2];
            data_q[wr_idx] <= fill_i.data;
        end
    end

    // read data travels with the item
    always_ff @(posedge clk) begin
        item_q.pc <= lookup_i.pc;
        word_q    <= data_q[rd_idx];
    end

    assign lookup_o = item_q;
    assign hit_o    = hit_q;
    assign data_o   = word_q;

endmodule

// File: logic/miss_fill.sv
// cache miss engine
// reads the four bytes of the missed word from byte wide memory,
// assembles them little endian and writes one fill to the cache
`timescale 1ns/1ns

module miss_fill import fetch_pkg::*; (
    input  logic       clk,
    input  logic       rst_n_i,
    input  lookup_t    miss_i,
    input  logic [7:0] mem_data_i,
    output logic       mem_rd_o,
    output addr_t      mem_addr_o,
    output fill_t      fill_o,
    output logic       busy_o
);

    addr_t      base_q;
    logic       rd_active_q;
    logic [1:0] rd_off_q;
    logic [1:0] cur_off;
    logic       cap_valid_q;
    logic [1:0] cap_idx_q;
    insn_word_u word_q;
    logic       fill_valid_q;

    // first read goes out in the request cycle itself
    assign cur_off    = miss_i.valid ? 2'd0 : rd_off_q;
    assign mem_rd_o   = miss_i.valid || rd_active_q;
    assign mem_addr_o = miss_i.valid ? miss_i.pc : {base_q[XLEN-1:2], rd_off_q};

    // busy until the last byte is in
    assign busy_o = miss_i.valid || rd_active_q || cap_valid_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            rd_active_q  <= 1'b0;
            rd_off_q     <= 2'd0;
            cap_valid_q  <= 1'b0;
            fill_valid_q <= 1'b0;
        end else begin
            if (miss_i.valid) begin
                rd_active_q <= 1'b1;
                rd_off_q    <= 2'd1;
            end else if (rd_active_q) begin
                rd_off_q <= rd_off_q + 2'd1;
                // byte 3 issued, stop reading
                if (rd_off_q == 2'd3) begin
                    rd_active_q <= 1'b0;
                end
            end
            cap_valid_q  <= mem_rd_o;
            fill_valid_q <= cap_valid_q && (cap_idx_q == 2'd3);
        end
    end

    // base address, byte lane of each read and the assembled word
    always_ff @(posedge clk) begin
        if (miss_i.valid) begin
            base_q <= miss_i.pc;
        end
        cap_idx_q <= cur_off;
        if (cap_valid_q) begin
            word_q.bytes[cap_idx_q] <= mem_data_i;
        end
    end

    assign fill_o.valid     = fill_valid_q;
    assign fill_o.pc        = base_q;
    assign fill_o.data.word = word_q.word;

    // a request reads four bytes back to back, then fills two cycles later
    a_read_run: assert property (@(posedge clk) disable iff (!rst_n_i)
        miss_i.valid |-> mem_rd_o ##1 mem_rd_o [*3] ##1 (!mem_rd_o && busy_o)
                         ##1 (fill_o.valid && !busy_o));

    // resolve never hands over a second miss while one is in progress
    a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n_i)
        miss_i.valid |-> !(rd_active_q || cap_valid_q));

endmodule

// File: logic/fetch_resolve.sv
// fetch resolve stage
// turns cache hits into decode items, starts the miss engine on a miss,
// squashes younger and redirected items and reports their credits
`timescale 1ns/1ns

module fetch_resolve import fetch_pkg::*; (
    input  logic       clk,
    input  logic       rst_n_i,
    input  lookup_t    item_i,
    input  logic       hit_i,
    input  insn_word_u data_i,
    input  redirect_t  redirect_i,
    input  fill_t      fill_word_i,
    output fetch_t     fetch_o,
    output lookup_t    miss_o,
    output redirect_t  resume_o,
    output logic [1:0] drop_cnt_o
);

    logic   pending_q;
    logic   killed_q;
    logic   flush_q;
    fetch_t fetch_q;

    logic item_kill;
    logic hit_ok;
    logic miss_req;
    logic item_drop;
    logic fill_ok;
    logic fill_drop;

    // item launched before a redirect still arrives one cycle later
    assign item_kill = redirect_i.valid || flush_q || pending_q;
    assign hit_ok    = item_i.valid && hit_i && !item_kill;
    assign miss_req  = item_i.valid && !hit_i && !item_kill;
    assign item_drop = item_i.valid && item_kill;

    // fill word only counts for a miss nobody redirected away from
    assign fill_ok   = fill_word_i.valid && !killed_q && !redirect_i.valid;
    assign fill_drop = fill_word_i.valid && !fill_ok;

    assign drop_cnt_o = {1'b0, item_drop} + {1'b0, fill_drop};

    assign miss_o.valid = miss_req;
    assign miss_o.pc    = item_i.pc;

    // restart after the missed word
    assign resume_o.valid = fill_ok;
    assign resume_o.pc    = fill_word_i.pc + XLEN'(4);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pending_q     <= 1'b0;
            killed_q      <= 1'b0;
            flush_q       <= 1'b0;
            fetch_q.valid <= 1'b0;
        end else begin
            flush_q       <= redirect_i.valid;
            fetch_q.valid <= hit_ok || fill_ok;
            if (fill_word_i.valid) begin
                pending_q <= 1'b0;
                killed_q  <= 1'b0;
            end else if (miss_req) begin
                pending_q <= 1'b1;
            end else if (pending_q && redirect_i.valid) begin
                killed_q <= 1'b1;
            end
        end
    end

    // decode payload, fill and hit are never both present
    always_ff @(posedge clk) begin
        if (fill_ok) begin
            fetch_q.pc   <= fill_word_i.pc;
            fetch_q.insn <= fill_word_i.data;
        end else if (hit_ok) begin
            fetch_q.pc   <= item_i.pc;
            fetch_q.insn <= data_i;
        end
    end

    assign fetch_o = fetch_q;

    // one miss at a time, the next only after its fill word is back
    a_single_miss: assert property (@(posedge clk) disable iff (!rst_n_i)
        miss_o.valid |=> (!miss_o.valid throughout fill_word_i.valid [->1]));

endmodule

// File: logic/fetch_top.sv
// instruction fetch front end, top level
// pc launch, cache read, resolve and the byte serial miss engine
`timescale 1ns/1ns

module fetch_top import fetch_pkg::*; #(
    parameter int INDEX_W = 4,
    parameter int CREDITS = 2
) (
    input  logic       clk,
    input  logic       rst_n_i,
    input  redirect_t  redirect_i,
    input  logic       credit_return_i,
    input  logic [7:0] mem_data_i,
    output fetch_t     fetch_o,
    output logic       mem_rd_o,
    output addr_t      mem_addr_o
);

    lookup_t    launch_item;
    lookup_t    read_item;
    logic       read_hit;
    insn_word_u read_word;
    lookup_t    miss_req;
    redirect_t  resume;
    logic [1:0] drop_cnt;
    fill_t      fill;
    logic       fill_busy;

    fetch_pc #(.CREDITS(CREDITS)) fetch_pc_inst (
        .clk(clk), .rst_n_i(rst_n_i), .redirect_i(redirect_i), .resume_i(resume),
        .drop_cnt_i(drop_cnt), .credit_return_i(credit_return_i),
        .fill_busy_i(fill_busy), .lookup_o(launch_item)
    );

    icache #(.INDEX_W(INDEX_W)) icache_inst (
        .clk(clk), .rst_n_i(rst_n_i), .lookup_i(launch_item), .fill_i(fill),
        .lookup_o(read_item), .hit_o(read_hit), .data_o(read_word)
    );

    fetch_resolve fetch_resolve_inst (
        .clk(clk), .rst_n_i(rst_n_i), .item_i(read_item), .hit_i(read_hit),
        .data_i(read_word), .redirect_i(redirect_i), .fill_word_i(fill),
        .fetch_o(fetch_o), .miss_o(miss_req), .resume_o(resume), .drop_cnt_o(drop_cnt)
    );

    miss_fill miss_fill_inst (
        .clk(clk), .rst_n_i(rst_n_i), .miss_i(miss_req), .mem_data_i(mem_data_i),
        .mem_rd_o(mem_rd_o), .mem_addr_o(mem_addr_o), .fill_o(fill), .busy_o(fill_busy)
    );

endmodule

// File: sim/fetch_tb.sv
// testbench for the instruction fetch front end
// random byte memory with one cycle read latency, credit based decode model,
// random redirects and a reference pc model that checks every fetched item
`timescale 1ns/1ns

module fetch_tb import fetch_pkg::*; ();

    localparam int INDEX_W    = 4;
    localparam int CREDITS    = 2;
    localparam int RUN_CYCLES = 6000;

    logic       clk = 1'b0;
    logic       rst_n_i;
    redirect_t  redirect_i;
    logic       credit_return_i;
    logic [7:0] mem_data_i = 8'd0;
    fetch_t     fetch_o;
    logic       mem_rd_o;
    addr_t      mem_addr_o;

    logic [7:0]         mem [1024];
    logic [7:0]         rd_byte_q = 8'd0;
    integer             seed;
    int                 errors = 0;
    int                 occupancy = 0;
    int                 delivered = 0;
    int                 idle_cycles = 0;
    int                 run_pos = 0;
    int                 runs = 0;
    int                 mode = 0;
    int                 wait_cnt = 0;
    int                 k;
    addr_t              expected_pc = '0;
    addr_t              run_base = '0;
    addr_t              loop_target = '0;
    logic               run_open = 1'b0;
    logic               run_excused = 1'b0;
    logic [INDEX_W-1:0] line_idx;
    // filled lines, indexed like a direct mapped cache
    logic               line_valid [1 << INDEX_W] = '{default: 1'b0};
    addr_t              line_addr [1 << INDEX_W];

    fetch_top #(.INDEX_W(INDEX_W), .CREDITS(CREDITS)) fetch_top_inst (
        .clk(clk), .rst_n_i(rst_n_i), .redirect_i(redirect_i),
        .credit_return_i(credit_return_i), .mem_data_i(mem_data_i),
        .fetch_o(fetch_o), .mem_rd_o(mem_rd_o), .mem_addr_o(mem_addr_o)
    );

    always #4 clk = ~clk;

    // little endian word from the byte memory
    function automatic logic [31:0] mem_word(addr_t pc);
        return {mem[pc[9:0] + 10'd3], mem[pc[9:0] + 10'd2],
                mem[pc[9:0] + 10'd1], mem[pc[9:0]]};
    endfunction

    task automatic stop_run(string what);
        errors++;
        $display("%s", what);
        $display("FAIL: see errors above");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
        if (actual !== expected) begin
            stop_run($sformatf("ERR %s expected %h actual %h", name, expected, actual));
        end
    endtask

    // reference model, sampled before the DUT registers update
    always @(posedge clk) begin
        if (rst_n_i) begin
            if (fetch_o.valid) begin
                if (delivered == 0) begin
                    check_value("first_pc", 32'd0, fetch_o.pc);
                end
                check_value("fetch_pc", expected_pc, fetch_o.pc);
                check_value("fetch_insn", mem_word(expected_pc), fetch_o.insn.word);
                run_open    = run_open && (fetch_o.pc != run_base);
                expected_pc = expected_pc + 32'd4;
                delivered++;
                occupancy++;
            end
            occupancy   = occupancy - int'(credit_return_i);
            idle_cycles = (fetch_o.valid || occupancy >= CREDITS) ? 0 : idle_cycles + 1;
            if (occupancy > CREDITS) begin
                stop_run("decode received more items than it had credits for");
            end
            // reads come in aligned runs of four bytes
            if (mem_rd_o) begin
                if (run_pos == 0) begin
                    line_idx = mem_addr_o[INDEX_W+1:2];
                    check_value("run_align", 32'd0, 32'(mem_addr_o[1:0]));
                    if (run_open && !run_excused) begin
                        stop_run("memory run started before the last word was delivered");
                    end
                    if (line_valid[line_idx] && line_addr[line_idx] == mem_addr_o) begin
                        stop_run("memory read for a word that is already cached");
                    end
                    line_valid[line_idx] = 1'b1;
                    line_addr[line_idx]  = mem_addr_o;
                    run_base    = mem_addr_o;
                    run_open    = 1'b0;
                    run_excused = 1'b0;
                end
                check_value("run_addr", run_base + addr_t'(run_pos), mem_addr_o);
                run_pos  = (run_pos + 1) % 4;
                run_open = run_open || (run_pos == 0);
                runs     = runs + int'(run_pos == 0);
            end else if (run_pos != 0) begin
                stop_run("memory run broke off before four bytes");
            end
            // old path ends at the redirect edge
            if (redirect_i.valid) begin
                expected_pc = redirect_i.pc;
                run_excused = 1'b1;
            end
        end
        if (mem_rd_o === 1'b1) begin
            rd_byte_q <= mem[mem_addr_o[9:0]];
        end
    end

    // memory byte arrives on the falling edge after the read cycle
    always @(negedge clk) begin
        mem_data_i <= rd_byte_q;
    end

    initial begin
        rst_n_i         = 1'b0;
        redirect_i      = '0;
        credit_return_i = 1'b0;
        seed            = 32'hbcfa_65c6;
        for (k = 0; k < 1024; k++) begin
            mem[k] = 8'($random(seed));
        end
        repeat (8) begin
            @(negedge clk);
            check_value("reset_fetch_valid", 32'd0, 32'(fetch_o.valid));
            check_value("reset_mem_rd", 32'd0, 32'(mem_rd_o));
        end
        rst_n_i = 1'b1;
        @(negedge clk);
        check_value("post_reset_fetch_valid", 32'd0, 32'(fetch_o.valid));
        check_value("post_reset_mem_rd", 32'd0, 32'(mem_rd_o));
        // first word is a miss from pc zero
        while (delivered == 0) begin
            @(negedge clk);
            wait_cnt++;
            if (wait_cnt > 50) begin
                stop_run("no instruction delivered after reset");
            end
        end
        for (k = 0; k < RUN_CYCLES; k++) begin
            @(negedge clk);
            // phase 0 fast decode, phase 1 slow, phase 2 returns nothing
            if (k % 256 == 0) begin
                mode = int'($unsigned($random(seed)) % 3);
            end
            credit_return_i = (occupancy > 0) && (mode != 2)
                              && ($unsigned($random(seed)) % (mode == 0 ? 2 : 8) == 0);
            redirect_i.valid = (k > 50) && ($unsigned($random(seed)) % 32 == 0);
            if (redirect_i.valid) begin
                // half the jumps go back to the last target so lines hit
                if ($unsigned($random(seed)) % 2 == 0) begin
                    loop_target = $unsigned($random(seed)) & 32'h0000_03fc;
                end
                redirect_i.pc = loop_target;
            end
            if (idle_cycles > 100) begin
                stop_run("no instruction delivered for 100 cycles with a free credit");
            end
        end
        redirect_i.valid = 1'b0;
        credit_return_i  = 1'b0;
        @(negedge clk);
        if (delivered <= runs) begin
            stop_run("no cache hits seen during the run");
        end
        if (errors == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            $display("FAIL: see errors above");
            $fatal(1, "errors found");
        end
    end

endmodule

// File: build.f
logic/fetch_pkg.sv
logic/fetch_pc.sv
logic/icache.sv
logic/miss_fill.sv
logic/fetch_resolve.sv
logic/fetch_top.sv
sim/fetch_tb.sv

// File: Makefile
# Verilator build and run for the instruction fetch front end
VERILATOR ?= verilator
TOP       ?= fetch_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 4
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the simulation exit status is the result of the run
run: build
	$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
